/* verilog/rv_isa_pkg.sv */
// RV32I subset only: no byte/halfword access, no lui/auipc, no CSRs
// encodings follow the base ISA spec, XLEN fixed at 32
package rv_isa_pkg;

  // data / address word and register index
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // major opcodes, instr[6:0]
  localparam logic [6:0] op_rtype  = 7'b0110011;
  localparam logic [6:0] op_itype  = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_system = 7'b1110011;  // ecall only

  // funct3 for R/I arithmetic
  localparam logic [2:0] f3_add = 3'b000;  // add, sub, addi
  localparam logic [2:0] f3_sll = 3'b001;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_srl = 3'b101;
  localparam logic [2:0] f3_or  = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // funct3 for branches
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;
  localparam logic [2:0] f3_blt = 3'b100;  // signed
  localparam logic [2:0] f3_bge = 3'b101;  // signed

  // funct7 marking sub among R-type add encodings
  localparam logic [6:0] f7_alt = 7'b0100000;

  // x17 (a7) value that makes ecall stop the core
  localparam word_t halt_code = 32'd10;

endpackage

/* verilog/core_ctrl_pkg.sv */
// control encodings internal to the core, not visible at the ISA level
package core_ctrl_pkg;

  // ALU operation select, driven by decoder
  typedef logic [3:0] alu_op_t;

  localparam alu_op_t alu_add = 4'd0;
  localparam alu_op_t alu_sub = 4'd1;
  localparam alu_op_t alu_and = 4'd2;
  localparam alu_op_t alu_or  = 4'd3;
  localparam alu_op_t alu_xor = 4'd4;
  localparam alu_op_t alu_slt = 4'd5;  // signed compare
  localparam alu_op_t alu_sll = 4'd6;
  localparam alu_op_t alu_srl = 4'd7;  // logical, no sra

  // register writeback source
  typedef logic [1:0] wb_sel_t;

  localparam wb_sel_t wb_alu = 2'd0;
  localparam wb_sel_t wb_mem = 2'd1;  // load data
  localparam wb_sel_t wb_pc4 = 2'd2;  // link address for jal/jalr

endpackage

/* verilog/decoder.sv */
// purely combinational; unknown opcodes decode to no register or memory write
// ALU control is folded in here, funct7 only checked for R-type sub
`timescale 1ns/1ps

module decoder
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;
(
  input  word_t   instr,
  output logic    reg_we,
  output logic    mem_we,
  output logic    alu_src_imm,
  output logic    is_branch,
  output logic    is_jal,
  output logic    is_jalr,
  output logic    is_ecall,
  output wb_sel_t wb_sel,
  output alu_op_t alu_op
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  alu_op_t    arith_op;  // funct3 mapping shared by R and I types

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // arithmetic op from funct3, sub only for R-type with alt funct7
  always_comb begin
    case (funct3)
      f3_add: arith_op = (opcode == op_rtype && funct7 == f7_alt) ? alu_sub : alu_add;
      f3_sll: arith_op = alu_sll;
      f3_slt: arith_op = alu_slt;
      f3_xor: arith_op = alu_xor;
      f3_srl: arith_op = alu_srl;
      f3_or:  arith_op = alu_or;
      f3_and: arith_op = alu_and;
      default: arith_op = alu_add;  // sltu not supported
    endcase
  end

  always_comb begin
    // safe defaults, nothing written
    reg_we      = 1'b0;
    mem_we      = 1'b0;
    alu_src_imm = 1'b0;
    is_branch   = 1'b0;
    is_jal      = 1'b0;
    is_jalr     = 1'b0;
    is_ecall    = 1'b0;
    wb_sel      = wb_alu;
    alu_op      = alu_add;  // address calc for load/store/jalr
    case (opcode)
      op_rtype: begin
        reg_we = 1'b1;
        alu_op = arith_op;
      end
      op_itype: begin
        reg_we      = 1'b1;
        alu_src_imm = 1'b1;
        alu_op      = arith_op;
      end
      op_load: begin
        reg_we      = 1'b1;
        alu_src_imm = 1'b1;
        wb_sel      = wb_mem;
      end
      op_store: begin
        mem_we      = 1'b1;
        alu_src_imm = 1'b1;  // rs1 + S-imm
      end
      op_branch: begin
        is_branch = 1'b1;
        alu_op    = alu_sub;  // compare rs1 vs rs2
      end
      op_jal: begin
        reg_we = 1'b1;
        is_jal = 1'b1;
        wb_sel = wb_pc4;
      end
      op_jalr: begin
        reg_we      = 1'b1;
        is_jalr     = 1'b1;
        alu_src_imm = 1'b1;
        wb_sel      = wb_pc4;
      end
      op_system: is_ecall = 1'b1;  // funct12 not checked
      default: ;
    endcase
  end

endmodule

/* verilog/imm_gen.sv */
// I, S, B and J layouts only; other opcodes give zero
`timescale 1ns/1ps

module imm_gen
  import rv_isa_pkg::*;
(
  input  word_t instr,
  output word_t imm
);

  logic [6:0] opcode;

  assign opcode = instr[6:0];

  always_comb begin
    case (opcode)
      // I format, also used by loads and jalr
      op_itype, op_load, op_jalr:
        imm = {{20{instr[31]}}, instr[31:20]};
      op_store:
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      // B format, bit 0 implicit zero
      op_branch:
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      // J format, 21-bit signed offset
      op_jal:
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      default:
        imm = '0;  // R-type and system need none
    endcase
  end

endmodule

/* verilog/alu.sv */
// shifts use b[4:0]; no arithmetic right shift
// bcond compares a and b directly, independent of alu_op
`timescale 1ns/1ps

module alu
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;
(
  input  alu_op_t    alu_op,
  input  logic [2:0] funct3,
  input  word_t      a,
  input  word_t      b,
  output word_t      result,
  output logic       bcond
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_xor: result = a ^ b;
      alu_slt: result = {31'b0, $signed(a) < $signed(b)};  // 0 or 1
      alu_sll: result = a << shamt;
      alu_srl: result = a >> shamt;
      default: result = '0;
    endcase
  end

  // branch condition, only meaningful for branch opcodes
  always_comb begin
    case (funct3)
      f3_beq:  bcond = (a == b);
      f3_bne:  bcond = (a != b);
      f3_blt:  bcond = ($signed(a) < $signed(b));
      f3_bge:  bcond = ($signed(a) >= $signed(b));
      default: bcond = 1'b0;  // bltu/bgeu unsupported
    endcase
  end

endmodule

/* verilog/register_file.sv */
// x0 reads zero and ignores writes; reads are combinational, no write bypass
`timescale 1ns/1ps

module register_file
  import rv_isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  word_t    rd_data,
  input  logic     we,
  output word_t    rs1_data,
  output word_t    rs2_data,
  output word_t    x17_data
);

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;  // whole file cleared
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];  // x0 hardwired
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];
  assign x17_data = regs[17];  // a7, for ecall halt check

endmodule

/* verilog/cpu.sv */
// single cycle, one instruction per clk; imem and dmem must answer combinationally
// stores commit at the rising edge with dmem_we; halt is sticky until reset
`timescale 1ns/1ps

module cpu
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  output word_t imem_addr,
  input  word_t imem_data,
  output word_t dmem_addr,
  output word_t dmem_wdata,
  output logic  dmem_we,
  input  word_t dmem_rdata,
  output logic  is_halted
);

  word_t      pc;
  word_t      next_pc;
  word_t      pc_plus4;
  word_t      pc_target;  // pc + imm, jal and branches
  logic       halted_q;
  logic       halt_now;

  // instruction fields
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  logic [2:0] funct3;

  // decoder outputs
  logic       reg_we;
  logic       mem_we;
  logic       alu_src_imm;
  logic       is_branch;
  logic       is_jal;
  logic       is_jalr;
  logic       is_ecall;
  wb_sel_t    wb_sel;
  alu_op_t    alu_op;

  word_t      imm;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      x17_data;
  word_t      alu_b;
  word_t      result;
  logic       bcond;
  word_t      wb_data;

  assign rs1    = imem_data[19:15];
  assign rs2    = imem_data[24:20];
  assign rd     = imem_data[11:7];
  assign funct3 = imem_data[14:12];

  decoder decoder_i (
    .instr       (imem_data),
    .reg_we      (reg_we),
    .mem_we      (mem_we),
    .alu_src_imm (alu_src_imm),
    .is_branch   (is_branch),
    .is_jal      (is_jal),
    .is_jalr     (is_jalr),
    .is_ecall    (is_ecall),
    .wb_sel      (wb_sel),
    .alu_op      (alu_op)
  );

  imm_gen imm_gen_i (
    .instr (imem_data),
    .imm   (imm)
  );

  register_file register_file_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .rd_data  (wb_data),
    .we       (reg_we & ~is_halted),  // no writeback once halted
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .x17_data (x17_data)
  );

  assign alu_b = alu_src_imm ? imm : rs2_data;

  alu alu_i (
    .alu_op (alu_op),
    .funct3 (funct3),
    .a      (rs1_data),
    .b      (alu_b),
    .result (result),
    .bcond  (bcond)
  );

  // writeback source
  always_comb begin
    case (wb_sel)
      wb_mem:  wb_data = dmem_rdata;
      wb_pc4:  wb_data = pc_plus4;  // link
      default: wb_data = result;
    endcase
  end

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm;

  // halted pc stays put, jalr target has bit 0 cleared
  always_comb begin
    if (is_halted)                      next_pc = pc;
    else if (is_jalr)                   next_pc = {result[31:1], 1'b0};
    else if (is_jal || (is_branch && bcond)) next_pc = pc_target;
    else                                next_pc = pc_plus4;
  end

  // halt visible in the ecall cycle itself, then held by halted_q
  assign halt_now  = is_ecall && (x17_data == halt_code);
  assign is_halted = halted_q | halt_now;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc       <= '0;
      halted_q <= 1'b0;
    end else begin
      pc <= next_pc;
      if (halt_now) halted_q <= 1'b1;  // sticky
    end
  end

  assign imem_addr  = pc;
  assign dmem_addr  = result;  // rs1 + imm for loads/stores
  assign dmem_wdata = rs2_data;
  assign dmem_we    = mem_we & ~is_halted;

endmodule

/* verification/cpu_ref_model.sv */
// instruction-level model of the RV32I subset, one step call per retired instruction
// data memory is its own 256-word copy, indexed by address bits 9:2
`timescale 1ns/1ps

module cpu_ref_model
  import rv_isa_pkg::*;
();

  word_t pc;
  word_t regs [32];  // regs[0] never written
  word_t dmem [256];
  logic  halted;

  task automatic reset_state();
    pc     = '0;
    halted = 1'b0;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
  endtask

  function automatic word_t sign_extend12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // R and I arithmetic, alt only set for R-type sub
  function automatic word_t arith(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      f3_add:  return alt ? a - b : a + b;
      f3_sll:  return a << b[4:0];
      f3_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      f3_xor:  return a ^ b;
      f3_srl:  return a >> b[4:0];
      f3_or:   return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic step(input word_t instr, output logic st_en, output word_t st_addr,
                      output word_t st_data);
    reg_idx_t   rd;
    logic [2:0] f3;
    word_t      a;
    word_t      b;
    word_t      ea;
    word_t      npc;
    word_t      wv;
    logic       wr;
    logic       taken;
    rd      = instr[11:7];
    f3      = instr[14:12];
    a       = regs[instr[19:15]];
    b       = regs[instr[24:20]];
    npc     = pc + 32'd4;
    wr      = 1'b0;
    wv      = '0;
    taken   = 1'b0;
    st_en   = 1'b0;
    st_addr = '0;
    st_data = '0;
    case (instr[6:0])
      op_rtype: begin
        wr = 1'b1;
        wv = arith(f3, instr[31:25] == f7_alt, a, b);
      end
      op_itype: begin
        wr = 1'b1;
        wv = arith(f3, 1'b0, a, sign_extend12(instr[31:20]));
      end
      op_load: begin
        ea = a + sign_extend12(instr[31:20]);
        wr = 1'b1;
        wv = dmem[ea[9:2]];
      end
      op_store: begin
        ea      = a + sign_extend12({instr[31:25], instr[11:7]});
        st_en   = 1'b1;
        st_addr = ea;
        st_data = b;
        dmem[ea[9:2]] = b;
      end
      op_branch: begin
        case (f3)
          f3_beq:  taken = (a == b);
          f3_bne:  taken = (a != b);
          f3_blt:  taken = ($signed(a) < $signed(b));
          default: taken = ($signed(a) >= $signed(b));
        endcase
        if (taken) begin
          npc = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        end
      end
      op_jal: begin
        wr  = 1'b1;
        wv  = pc + 32'd4;
        npc = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      op_jalr: begin
        ea  = a + sign_extend12(instr[31:20]);  // target read before rd write
        wr  = 1'b1;
        wv  = pc + 32'd4;
        npc = {ea[31:1], 1'b0};
      end
      op_system: begin
        if (regs[17] == halt_code) begin
          halted = 1'b1;
          npc    = pc;  // pc frozen from here on
        end
      end
      default: ;
    endcase
    if (wr && rd != 5'd0) regs[rd] = wv;
    pc = npc;
  endtask

endmodule

/* verification/tb_cpu.sv */
// random forward-only program, so every run ends at the closing ecall
// imem and dmem modeled here, both answer combinationally on address bits 9:2
`timescale 1ns/1ps

module tb_cpu
  import rv_isa_pkg::*;
();

  localparam int prog_len = 200;
  localparam int timeout  = 2000;  // cycles

  logic  clk;
  logic  rst_n;
  logic  dmem_we;
  logic  is_halted;
  word_t imem_addr;
  word_t imem_data;
  word_t dmem_addr;
  word_t dmem_wdata;
  word_t dmem_rdata;

  word_t imem [256];
  word_t dmem [256];
  logic  jalr_slot [256];  // slot holds the jalr of an addi x21 / jalr pair
  int    errs [1:5];       // error count per test
  int    cycles;
  int    failed;
  logic  st_en;
  word_t st_addr;
  word_t st_data;
  word_t exp_pc;
  word_t halt_pc;

  initial clk = 1'b0;
  always #50 clk = ~clk;

  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) dmem[dmem_addr[9:2]] <= dmem_wdata;
  end

  cpu cpu_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata),
    .is_halted  (is_halted)
  );

  cpu_ref_model model_i ();

  function automatic word_t rtype_word(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                       logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, op_rtype};
  endfunction

  function automatic word_t itype_word(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                       reg_idx_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t branch_word(int off, reg_idx_t rs2, reg_idx_t rs1, logic [2:0] f3);
    logic [12:0] o;
    o = off[12:0];
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], op_branch};
  endfunction

  function automatic word_t jal_word(int off, reg_idx_t rd);
    logic [20:0] o;
    o = off[20:0];
    return {o[20], o[10:1], o[11], o[19:12], rd, op_jal};
  endfunction

  function automatic reg_idx_t random_reg();
    return reg_idx_t'($urandom_range(15, 0));  // x0..x15, x17/x20/x21 kept apart
  endfunction

  function automatic logic [2:0] arith_funct3(int sel);
    case (sel)
      0:       return f3_add;
      1:       return f3_slt;
      2:       return f3_xor;
      3:       return f3_or;
      4:       return f3_and;
      5:       return f3_sll;
      default: return f3_srl;
    endcase
  endfunction

  function automatic logic [2:0] branch_funct3(int sel);
    case (sel)
      0:       return f3_beq;
      1:       return f3_bne;
      2:       return f3_blt;
      default: return f3_bge;
    endcase
  endfunction

  // forward distance 1..8 words, never past the x17 setup, never onto a lone jalr
  function automatic int jump_distance(int i);
    int k;
    k = $urandom_range(8, 1);
    if (i + k > prog_len - 2) k = prog_len - 2 - i;
    if (jalr_slot[i + k]) k = k - 1;  // land on its addi instead
    return k;
  endfunction

  task automatic build_program();
    int sel;
    int k;
    for (int i = 0; i < 256; i++) begin
      imem[i]      = itype_word(12'(i), 5'd0, f3_add, 5'd0, op_itype);  // nop, imm tags slot
      jalr_slot[i] = 1'b0;
    end
    for (int i = 2; i < prog_len - 3; i++) begin
      if (!jalr_slot[i] && $urandom_range(15, 0) == 0) jalr_slot[i + 1] = 1'b1;
    end
    for (int i = 0; i < prog_len - 2; i++) begin
      if (jalr_slot[i]) begin
        imem[i] = itype_word(12'd1, 5'd21, 3'b000, random_reg(), op_jalr);  // odd target
      end else if (jalr_slot[i + 1]) begin
        k       = i + 1 + jump_distance(i + 1);
        imem[i] = itype_word(12'(k * 4), 5'd0, f3_add, 5'd21, op_itype);
      end else begin
        // start with a base, then an ecall that must not halt
        sel = (i == 0) ? 5 : (i == 1) ? 10 : $urandom_range(9, 0);
        case (sel)
          0, 1, 2: begin
            k       = $urandom_range(7, 0);  // 7 selects sub
            imem[i] = rtype_word((k == 7) ? f7_alt : 7'd0, random_reg(), random_reg(),
                                 arith_funct3(k % 7), random_reg());
          end
          3, 4: imem[i] = itype_word(12'($urandom), random_reg(),
                                     arith_funct3($urandom_range(4, 0)), random_reg(), op_itype);
          5: imem[i] = itype_word(12'($urandom_range(255, 0) * 4), 5'd0, f3_add, 5'd20,
                                  op_itype);
          6: imem[i] = itype_word(12'd0, 5'd20, 3'b010, random_reg(), op_load);  // lw
          7: imem[i] = {7'd0, random_reg(), 5'd20, 3'b010, 5'd0, op_store};      // sw
          8: imem[i] = branch_word(jump_distance(i) * 4, random_reg(), random_reg(),
                                   branch_funct3($urandom_range(3, 0)));
          10: imem[i] = {25'd0, op_system};  // x17 still 0 here
          default: imem[i] = jal_word(jump_distance(i) * 4, random_reg());
        endcase
      end
    end
    imem[prog_len - 2] = itype_word(12'd10, 5'd0, f3_add, 5'd17, op_itype);
    imem[prog_len - 1] = {25'd0, op_system};  // ecall
  endtask

  task automatic check_word(input int test, input string name, input word_t got,
                            input word_t exp);
    assert (got === exp) else begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      errs[test]++;
    end
  endtask

  task automatic report_test(input int test, input string what);
    $display("test %0d %s: %s (%0d errors)", test, what,
             (errs[test] == 0) ? "ok" : "FAILED", errs[test]);
  endtask

  initial begin
    void'($urandom(32'h0fa0e5b4));
    rst_n = 1'b0;
    for (int t = 1; t <= 5; t++) errs[t] = 0;
    build_program();
    for (int i = 0; i < 256; i++) begin
      dmem[i]         = 32'h9e37_79b9 * (i + 1) ^ 32'h0000_5a5a;
      model_i.dmem[i] = dmem[i];
    end
    model_i.reset_state();

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_word(1, "imem_addr", imem_addr, 32'd0);
    check_word(1, "dmem_we", dmem_we, 32'd0);
    check_word(1, "is_halted", is_halted, 32'd0);
    report_test(1, "reset state");

    // lockstep with the model until it reaches the halting ecall
    cycles = 0;
    while (!model_i.halted && cycles < timeout) begin
      exp_pc = model_i.pc;
      model_i.step(imem[exp_pc[9:2]], st_en, st_addr, st_data);
      check_word(2, "imem_addr", imem_addr, exp_pc);
      check_word(3, "dmem_we", dmem_we, st_en);
      if (st_en) begin
        check_word(3, "dmem_addr", dmem_addr, st_addr);
        check_word(3, "dmem_wdata", dmem_wdata, st_data);
      end
      check_word(4, "is_halted", is_halted, model_i.halted);
      @(negedge clk);
      cycles++;
    end

    if (!model_i.halted) begin
      $display("timeout: program did not reach the halting ecall within %0d cycles", timeout);
      errs[2]++;
      report_test(2, "pc tracking");
    end else begin
      report_test(2, "pc tracking");
      report_test(3, "store traffic");
      halt_pc = model_i.pc;
      // ecall swapped for a sw so only the held halt flag keeps the core stopped
      imem[halt_pc[9:2]] = {7'd0, 5'd1, 5'd20, 3'b010, 5'd0, op_store};
      repeat (10) begin
        check_word(4, "is_halted", is_halted, 32'd1);
        check_word(5, "imem_addr", imem_addr, halt_pc);
        check_word(5, "dmem_we", dmem_we, 32'd0);
        @(negedge clk);
      end
      report_test(4, "halt on ecall");
      report_test(5, "halted hold");
    end

    failed = 0;
    for (int t = 1; t <= 5; t++) begin
      if (errs[t] != 0) failed++;
    end
    $display("tests 5, passed %0d, failed %0d, cycles run %0d", 5 - failed, failed, cycles);
    if (failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
verilog/rv_isa_pkg.sv
verilog/core_ctrl_pkg.sv
verilog/decoder.sv
verilog/imm_gen.sv
verilog/alu.sv
verilog/register_file.sv
verilog/cpu.sv
verification/cpu_ref_model.sv
verification/tb_cpu.sv

/* Bender.yml */
package:
  name: rv32i_single_cycle

sources:
  - files:
      - verilog/rv_isa_pkg.sv
      - verilog/core_ctrl_pkg.sv
      - verilog/decoder.sv
      - verilog/imm_gen.sv
      - verilog/alu.sv
      - verilog/register_file.sv
      - verilog/cpu.sv
  - target: simulation
    files:
      - verification/cpu_ref_model.sv
      - verification/tb_cpu.sv
